//--- Bender.yml
package:
  name: i2c_handler

sources:
  - design/i2c_handler_pkg.sv
  - design/handler_ctrl.sv
  - design/cmd_capture.sv
  - design/upload_queue.sv
  - design/i2c_handler.sv
  - target: test
    files:
      - testbench/tb_i2c_handler.sv

//--- compile.f
design/i2c_handler_pkg.sv
design/handler_ctrl.sv
design/cmd_capture.sv
design/upload_queue.sv
design/i2c_handler.sv
testbench/tb_i2c_handler.sv

//--- design/cmd_capture.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_capture #(
    parameter int TX_DEPTH = i2c_handler_pkg::TX_DEPTH_DEFAULT
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          cap_cfg,
    input  wire                          cap_tx,
    input  wire                          cap_rx,
    input  wire                          cmd_data_valid,
    input  wire i2c_handler_pkg::count_t cmd_data_index,
    input  wire i2c_handler_pkg::byte_t  cmd_data,
    input  wire i2c_handler_pkg::byte_t  offset,
    output i2c_handler_pkg::slave_addr_t device_id,
    output i2c_handler_pkg::reg_addr_t   base_reg,
    output i2c_handler_pkg::count_t      rx_len,
    output i2c_handler_pkg::byte_t       wr_data
);
    import i2c_handler_pkg::*;

    // buffer index width
    localparam int TX_AW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;

    byte_t  tx_buf [TX_DEPTH];
    // payload byte k lands in slot k-1
    count_t slot;
    logic   buf_we;
    logic   data_first;

    assign slot       = cmd_data_index - 16'd1;
    assign data_first = (cmd_data_index == '0);

    // bytes beyond the buffer are dropped
    assign buf_we = cap_tx && cmd_data_valid && !data_first &&
                    (cmd_data_index <= count_t'(TX_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            device_id <= '0;
            base_reg  <= '0;
            rx_len    <= '0;
        end else if (cmd_data_valid) begin
            // config bytes 0..3 held the clock word, now unused
            if (cap_cfg && (cmd_data_index == 16'd4)) begin
                device_id <= cmd_data[6:0];
            end
            // byte 0 of a write or read is the base register
            if ((cap_tx || cap_rx) && data_first) begin
                base_reg <= cmd_data;
            end
            // read length arrives high byte first
            if (cap_rx && (cmd_data_index == 16'd1)) begin
                rx_len[15:8] <= cmd_data;
            end
            if (cap_rx && (cmd_data_index == 16'd2)) begin
                rx_len[7:0] <= cmd_data;
            end
        end
    end

    // write data buffer
    always_ff @(posedge clk) begin
        if (buf_we) begin
            tx_buf[slot[TX_AW-1:0]] <= cmd_data;
        end
    end

    // byte for the current write request, stable while offset holds
    assign wr_data = tx_buf[offset[TX_AW-1:0]];

endmodule

`default_nettype wire

//--- design/handler_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module handler_ctrl #(
    parameter int TX_DEPTH = i2c_handler_pkg::TX_DEPTH_DEFAULT
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire i2c_handler_pkg::byte_t     cmd_type,
    input  wire i2c_handler_pkg::count_t    cmd_length,
    input  wire                             cmd_start,
    input  wire                             cmd_done,
    input  wire                             rw_done,
    input  wire i2c_handler_pkg::count_t    rx_len,
    input  wire i2c_handler_pkg::reg_addr_t base_reg,
    input  wire                             upq_full,
    input  wire                             upq_empty,
    output logic                            cmd_ready,
    output logic                            cap_cfg,
    output logic                            cap_tx,
    output logic                            cap_rx,
    output logic                            wr_req,
    output logic                            rd_req,
    output i2c_handler_pkg::byte_t          offset,
    output i2c_handler_pkg::reg_addr_t      reg_addr,
    output logic                            push
);
    import i2c_handler_pkg::*;

    // write jobs never run past the buffer
    localparam count_t TX_MAX = count_t'(TX_DEPTH);

    handler_state_t state;
    // requests still to complete in the current job
    count_t         remaining;
    // one request outstanding at the external controller
    logic           in_flight;
    // data bytes in a write payload, byte 0 being the register
    count_t         tx_len;

    assign tx_len = cmd_length - 16'd1;

    // commands are accepted while idle or capturing
    assign cmd_ready = (state == ST_IDLE) || (state == ST_CAP_CFG) ||
                       (state == ST_CAP_TX) || (state == ST_CAP_RX);

    // one-hot capture enables for the payload datapath
    assign cap_cfg = (state == ST_CAP_CFG);
    assign cap_tx  = (state == ST_CAP_TX);
    assign cap_rx  = (state == ST_CAP_RX);

    // register address wraps modulo 256
    assign reg_addr = base_reg + offset;

    // read data is valid together with rw_done
    assign push = (state == ST_READ) && in_flight && rw_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            remaining <= '0;
            offset    <= '0;
            in_flight <= 1'b0;
            wr_req    <= 1'b0;
            rd_req    <= 1'b0;
        end else begin
            // request strobes are single-cycle pulses
            wr_req <= 1'b0;
            rd_req <= 1'b0;

            // completion of the outstanding request moves to the next byte
            if (in_flight && rw_done) begin
                in_flight <= 1'b0;
                remaining <= remaining - 16'd1;
                offset    <= offset + 8'd1;
            end

            case (state)
                ST_IDLE: begin
                    if (cmd_start) begin
                        case (cmd_type)
                            CMD_I2C_CONFIG: state <= ST_CAP_CFG;
                            CMD_I2C_TX:     state <= ST_CAP_TX;
                            CMD_I2C_RX:     state <= ST_CAP_RX;
                            // unknown codes are dropped
                            default:        state <= ST_IDLE;
                        endcase
                    end
                end
                ST_CAP_CFG: begin
                    if (cmd_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_CAP_TX: begin
                    if (cmd_done) begin
                        offset <= '0;
                        if (cmd_length == '0) begin
                            state <= ST_IDLE;
                        end else begin
                            remaining <= (tx_len > TX_MAX) ? TX_MAX : tx_len;
                            state     <= ST_WRITE;
                        end
                    end
                end
                ST_CAP_RX: begin
                    if (cmd_done) begin
                        offset    <= '0;
                        remaining <= rx_len;
                        state     <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (!in_flight) begin
                        if (remaining == '0) begin
                            state <= ST_IDLE;
                        end else begin
                            wr_req    <= 1'b1;
                            in_flight <= 1'b1;
                        end
                    end
                end
                ST_READ: begin
                    // hold off the next read while the queue has no room
                    if (!in_flight) begin
                        if (remaining == '0) begin
                            state <= ST_DRAIN;
                        end else if (!upq_full) begin
                            rd_req    <= 1'b1;
                            in_flight <= 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (upq_empty) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_handler.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_handler #(
    parameter int TX_DEPTH  = i2c_handler_pkg::TX_DEPTH_DEFAULT,
    parameter int UPQ_DEPTH = i2c_handler_pkg::UPQ_DEPTH_DEFAULT
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire i2c_handler_pkg::byte_t  cmd_type,
    input  wire i2c_handler_pkg::count_t cmd_length,
    input  wire i2c_handler_pkg::byte_t  cmd_data,
    input  wire i2c_handler_pkg::count_t cmd_data_index,
    input  wire                          cmd_start,
    input  wire                          cmd_data_valid,
    input  wire                          cmd_done,
    input  wire i2c_handler_pkg::byte_t  rd_data,
    input  wire                          rw_done,
    input  wire                          upload_ready,
    output logic                         cmd_ready,
    output logic                         wr_req,
    output logic                         rd_req,
    output i2c_handler_pkg::reg_addr_t   reg_addr,
    output i2c_handler_pkg::byte_t       wr_data,
    output i2c_handler_pkg::slave_addr_t device_id,
    output logic                         upload_valid,
    output i2c_handler_pkg::byte_t       upload_data
);
    import i2c_handler_pkg::*;

    // capture enables from the FSM
    logic      cap_cfg;
    logic      cap_tx;
    logic      cap_rx;
    // byte position within the running job
    byte_t     offset;
    reg_addr_t base_reg;
    count_t    rx_len;
    logic      upq_full;
    logic      upq_empty;
    logic      push;

    handler_ctrl #(
        .TX_DEPTH (TX_DEPTH)
    ) u_ctrl (
        .clk, .rst_n, .cmd_type, .cmd_length, .cmd_start, .cmd_done, .rw_done,
        .rx_len, .base_reg, .upq_full, .upq_empty,
        .cmd_ready, .cap_cfg, .cap_tx, .cap_rx, .wr_req, .rd_req,
        .offset, .reg_addr, .push
    );

    cmd_capture #(
        .TX_DEPTH (TX_DEPTH)
    ) u_capture (
        .clk, .rst_n, .cap_cfg, .cap_tx, .cap_rx,
        .cmd_data_valid, .cmd_data_index, .cmd_data, .offset,
        .device_id, .base_reg, .rx_len, .wr_data
    );

    // read bytes go out to the host while reads continue
    upload_queue #(
        .UPQ_DEPTH (UPQ_DEPTH)
    ) u_upq (
        .clk, .rst_n, .push, .rd_data, .upload_ready,
        .upq_full, .upq_empty, .upload_valid, .upload_data
    );

endmodule

`default_nettype wire

//--- design/i2c_handler_pkg.sv
`default_nettype none

package i2c_handler_pkg;

    // data byte for payload, write data, read data and upload data
    typedef logic [7:0] byte_t;
    // i2c register address, 8-bit mode only
    typedef logic [7:0] reg_addr_t;
    // 7-bit i2c device address
    typedef logic [6:0] slave_addr_t;
    // payload length or byte count of a job
    typedef logic [15:0] count_t;

    // command type codes
    localparam byte_t CMD_I2C_CONFIG = 8'h04;
    localparam byte_t CMD_I2C_TX     = 8'h05;
    localparam byte_t CMD_I2C_RX     = 8'h06;

    // write buffer and upload queue depths, powers of two
    localparam int TX_DEPTH_DEFAULT  = 256;
    localparam int UPQ_DEPTH_DEFAULT = 256;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAP_CFG,
        ST_CAP_TX,
        ST_CAP_RX,
        ST_WRITE,
        ST_READ,
        ST_DRAIN
    } handler_state_t;

endpackage

`default_nettype wire

//--- design/upload_queue.sv
`timescale 1ns/1ps
`default_nettype none

module upload_queue #(
    parameter int UPQ_DEPTH = i2c_handler_pkg::UPQ_DEPTH_DEFAULT
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         push,
    input  wire i2c_handler_pkg::byte_t rd_data,
    input  wire                         upload_ready,
    output logic                        upq_full,
    output logic                        upq_empty,
    output logic                        upload_valid,
    output i2c_handler_pkg::byte_t      upload_data
);
    import i2c_handler_pkg::*;

    localparam int AW = (UPQ_DEPTH > 1) ? $clog2(UPQ_DEPTH) : 1;

    byte_t         mem [UPQ_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    // set in the cycle after a strobe to space the bytes out
    logic          gap;
    logic          do_push;

    assign upq_full  = (count == (AW+1)'(UPQ_DEPTH));
    assign upq_empty = (count == '0);
    assign do_push   = push && !upq_full;

    // strobe only while the receiver is ready, the byte leaves in that cycle
    assign upload_valid = !upq_empty && upload_ready && !gap;
    assign upload_data  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            gap    <= 1'b0;
        end else begin
            gap <= upload_valid;
            // pointers wrap naturally at a power-of-two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (upload_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, upload_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_i2c_handler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_handler;
    import i2c_handler_pkg::*;

    // bus requests expected over all tests, sizes the watchdog
    localparam int N_REQ          = 20 + 12 + 300;
    localparam int TIMEOUT_CYCLES = 200 * N_REQ + 2000;

    logic        clk;
    logic        rst_n;
    byte_t       cmd_type;
    count_t      cmd_length;
    byte_t       cmd_data;
    count_t      cmd_data_index;
    logic        cmd_start;
    logic        cmd_data_valid;
    logic        cmd_done;
    byte_t       rd_data;
    logic        rw_done;
    logic        upload_ready;
    logic        cmd_ready;
    logic        wr_req;
    logic        rd_req;
    reg_addr_t   reg_addr;
    byte_t       wr_data;
    slave_addr_t device_id;
    logic        upload_valid;
    byte_t       upload_data;

    integer      seed;
    int          cycles;
    int          errors;
    int          errors_at_start;
    int          tests_ok;
    int          tests_bad;
    logic        ready_random;
    // controller model registers and the reference copy, indexed {device, register}
    byte_t       model_regs [32768];
    byte_t       ref_regs [32768];
    byte_t       payload [$];
    // {is_read, device_id, reg_addr, wr_data}
    logic [23:0] exp_req [$];
    byte_t       exp_up [$];

    i2c_handler #(
        .TX_DEPTH  (TX_DEPTH_DEFAULT),
        .UPQ_DEPTH (UPQ_DEPTH_DEFAULT)
    ) dut (
        .clk, .rst_n, .cmd_type, .cmd_length, .cmd_data, .cmd_data_index,
        .cmd_start, .cmd_data_valid, .cmd_done, .rd_data, .rw_done, .upload_ready,
        .cmd_ready, .wr_req, .rd_req, .reg_addr, .wr_data, .device_id,
        .upload_valid, .upload_data
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // power-on contents, every bit of the address matters
    function automatic byte_t fill_byte(input logic [14:0] a);
        return (a[7:0] * 8'd37) ^ {1'b0, a[14:8]} ^ 8'ha5;
    endfunction

    // expected requests and upload bytes of one job
    function automatic void expect_job(input logic is_rd, input slave_addr_t dev,
                                       input byte_t base, input int n);
        reg_addr_t a;
        for (int i = 0; i < n; i++) begin
            a = base + i[7:0];
            if (is_rd) begin
                exp_req.push_back({1'b1, dev, a, 8'h00});
                exp_up.push_back(ref_regs[{dev, a}]);
            end else begin
                exp_req.push_back({1'b0, dev, a, payload[i+1]});
                ref_regs[{dev, a}] = payload[i+1];
            end
        end
    endfunction

    // start, indexed payload bytes, then the done pulse
    task automatic send_cmd(input byte_t ctype);
        @(posedge clk);
        #2;
        cmd_type   = ctype;
        cmd_length = count_t'(payload.size());
        cmd_start  = 1'b1;
        @(posedge clk);
        #2;
        cmd_start = 1'b0;
        for (int i = 0; i < payload.size(); i++) begin
            cmd_data       = payload[i];
            cmd_data_index = count_t'(i);
            cmd_data_valid = 1'b1;
            @(posedge clk);
            #2;
        end
        cmd_data_valid = 1'b0;
        cmd_done       = 1'b1;
        @(posedge clk);
        #2;
        cmd_done = 1'b0;
    endtask

    // job is over once the FSM is back and every expected pulse was seen
    task automatic wait_job();
        while (!(cmd_ready && exp_req.size() == 0 && exp_up.size() == 0)) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_ok = tests_ok + 1;
            $display("%s: ok", name);
        end else begin
            tests_bad = tests_bad + 1;
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // external controller, answers each request after 1 to 6 cycles
    initial begin
        int          delay;
        logic        is_rd;
        logic [14:0] a;
        rw_done = 1'b0;
        rd_data = 8'h00;
        forever begin
            @(negedge clk);
            if (rst_n && (wr_req || rd_req)) begin
                is_rd = rd_req;
                a     = {device_id, reg_addr};
                if (!is_rd) begin
                    model_regs[a] = wr_data;
                end
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(posedge clk);
                #2;
                rd_data = is_rd ? model_regs[a] : 8'h00;
                rw_done = 1'b1;
                @(posedge clk);
                #2;
                rw_done = 1'b0;
            end
        end
    end

    // host readiness, long random stalls when enabled
    initial begin
        int stretch;
        upload_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            if (ready_random) begin
                upload_ready = 1'b0;
                stretch = 2000 + ($unsigned($random(seed)) % 1000);
                repeat (stretch) @(posedge clk);
                #2 upload_ready = 1'b1;
                stretch = 40 + ($unsigned($random(seed)) % 60);
                repeat (stretch) @(posedge clk);
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        logic [23:0] e;
        if (rst_n && (wr_req || rd_req)) begin
            if (exp_req.size() == 0) begin
                $display("unexpected request at register %h", reg_addr);
                errors = errors + 1;
            end else begin
                e = exp_req.pop_front();
                if (rd_req !== e[23]) begin
                    $display("mismatch rd_req: expected %h, got %h", e[23], rd_req);
                    errors = errors + 1;
                end
                if (device_id !== e[22:16]) begin
                    $display("mismatch device_id: expected %h, got %h", e[22:16], device_id);
                    errors = errors + 1;
                end
                if (reg_addr !== e[15:8]) begin
                    $display("mismatch reg_addr: expected %h, got %h", e[15:8], reg_addr);
                    errors = errors + 1;
                end
                if (!e[23] && wr_data !== e[7:0]) begin
                    $display("mismatch wr_data: expected %h, got %h", e[7:0], wr_data);
                    errors = errors + 1;
                end
            end
        end
        if (rst_n && upload_valid) begin
            if (!upload_ready) begin
                $display("upload strobe while the host was not ready");
                errors = errors + 1;
            end
            if (exp_up.size() == 0) begin
                $display("unexpected upload of byte %h", upload_data);
                errors = errors + 1;
            end else if (upload_data !== exp_up[0]) begin
                $display("mismatch upload_data: expected %h, got %h", exp_up[0], upload_data);
                errors = errors + 1;
                void'(exp_up.pop_front());
            end else begin
                void'(exp_up.pop_front());
            end
        end
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the DUT did not finish its jobs within %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed            = 35;
        errors          = 0;
        errors_at_start = 0;
        tests_ok        = 0;
        tests_bad       = 0;
        ready_random    = 1'b0;
        rst_n           = 1'b0;
        cmd_type        = 8'h00;
        cmd_length      = '0;
        cmd_data        = 8'h00;
        cmd_data_index  = '0;
        cmd_start       = 1'b0;
        cmd_data_valid  = 1'b0;
        cmd_done        = 1'b0;
        for (int i = 0; i < 32768; i++) begin
            model_regs[i] = fill_byte(15'(i));
            ref_regs[i]   = fill_byte(15'(i));
        end
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;

        // reset values, then an unknown command type
        @(negedge clk);
        if (wr_req !== 1'b0 || rd_req !== 1'b0 || upload_valid !== 1'b0 ||
            cmd_ready !== 1'b1 || device_id !== 7'h00) begin
            $display("outputs after reset are not idle");
            errors = errors + 1;
        end
        payload = '{8'h01, 8'h02};
        send_cmd(8'h07);
        repeat (20) @(negedge clk);
        if (!cmd_ready) begin
            $display("cmd_ready dropped after an unknown command");
            errors = errors + 1;
        end
        end_test("test 1 reset and unknown command");

        payload = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h50};
        send_cmd(CMD_I2C_CONFIG);
        @(negedge clk);
        if (device_id !== 7'h50) begin
            $display("mismatch device_id: expected %h, got %h", 7'h50, device_id);
            errors = errors + 1;
        end
        end_test("test 2 config");

        // 20 bytes from F0 wrap past FF
        payload = '{8'hf0};
        repeat (20) payload.push_back(byte_t'($random(seed)));
        expect_job(1'b0, 7'h50, 8'hf0, 20);
        send_cmd(CMD_I2C_TX);
        wait_job();
        end_test("test 3 write with wrap");

        payload = '{8'h10, 8'h00, 8'd12};
        expect_job(1'b1, 7'h50, 8'h10, 12);
        send_cmd(CMD_I2C_RX);
        wait_job();
        end_test("test 4 read");

        // long read across the written bytes with the host stalling
        payload = '{8'he8, 8'h01, 8'h2c};
        expect_job(1'b1, 7'h50, 8'he8, 300);
        ready_random = 1'b1;
        send_cmd(CMD_I2C_RX);
        wait_job();
        ready_random = 1'b0;
        end_test("test 5 long read with stalls");

        $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
